/* hdl/exu_pkg.sv */
`default_nettype none

package exu_pkg;

    localparam int xlen       = 32;
    localparam int reg_addr_w = 5;
    localparam int num_regs   = 32;

    // major opcodes handled by the unit
    localparam logic [6:0] op_rtype  = 7'b0110011;
    localparam logic [6:0] op_itype  = 7'b0010011;
    localparam logic [6:0] op_lui    = 7'b0110111;
    localparam logic [6:0] op_auipc  = 7'b0010111;
    localparam logic [6:0] op_branch = 7'b1100011;
    localparam logic [6:0] op_jal    = 7'b1101111;
    localparam logic [6:0] op_jalr   = 7'b1100111;

    // instruction classes
    localparam logic [2:0] cls_alu    = 3'd0;
    localparam logic [2:0] cls_jal    = 3'd1;
    localparam logic [2:0] cls_jalr   = 3'd2;
    localparam logic [2:0] cls_branch = 3'd3;
    localparam logic [2:0] cls_none   = 3'd4; // unknown opcode or bad funct

    localparam logic [3:0] alu_add    = 4'd0;
    localparam logic [3:0] alu_sub    = 4'd1;
    localparam logic [3:0] alu_sll    = 4'd2;
    localparam logic [3:0] alu_slt    = 4'd3;
    localparam logic [3:0] alu_sltu   = 4'd4;
    localparam logic [3:0] alu_xor    = 4'd5;
    localparam logic [3:0] alu_srl    = 4'd6;
    localparam logic [3:0] alu_sra    = 4'd7;
    localparam logic [3:0] alu_or     = 4'd8;
    localparam logic [3:0] alu_and    = 4'd9;
    localparam logic [3:0] alu_pass_b = 4'd10; // lui

    // branch conditions
    localparam logic [2:0] f3_beq  = 3'b000;
    localparam logic [2:0] f3_bne  = 3'b001;
    localparam logic [2:0] f3_blt  = 3'b100;
    localparam logic [2:0] f3_bge  = 3'b101;
    localparam logic [2:0] f3_bltu = 3'b110;
    localparam logic [2:0] f3_bgeu = 3'b111;

    localparam logic [6:0] f7_alt = 7'b0100000; // sub / sra

    // controller states
    localparam logic [1:0] st_idle      = 2'd0;
    localparam logic [1:0] st_execute   = 2'd1;
    localparam logic [1:0] st_writeback = 2'd2;

    typedef struct packed {
        logic [6:0]            funct7;
        logic [reg_addr_w-1:0] rs2;
        logic [reg_addr_w-1:0] rs1;
        logic [2:0]            funct3;
        logic [reg_addr_w-1:0] rd;
        logic [6:0]            opcode;
    } r_fmt_t;

    typedef struct packed {
        logic [11:0]           imm12;
        logic [reg_addr_w-1:0] rs1;
        logic [2:0]            funct3;
        logic [reg_addr_w-1:0] rd;
        logic [6:0]            opcode;
    } i_fmt_t;

    typedef union packed {
        r_fmt_t r_fmt;
        i_fmt_t i_fmt;
    } instr_u;

    typedef struct packed {
        logic [2:0]            cls;
        logic [3:0]            alu_op;
        logic [2:0]            funct3;
        logic                  a_is_pc;
        logic                  b_is_imm;
        logic [xlen-1:0]       imm;
        logic [reg_addr_w-1:0] rd;
        logic [reg_addr_w-1:0] rs1;
        logic [reg_addr_w-1:0] rs2;
        logic                  rd_wen;
    } decoded_t;

    typedef struct packed {
        logic                  valid;
        logic [reg_addr_w-1:0] rd;
        logic [xlen-1:0]       data;
    } commit_t;

endpackage

`default_nettype wire

/* hdl/exu_decoder.sv */
`default_nettype none

module exu_decoder (
    input  exu_pkg::instr_u   instr_i,
    output exu_pkg::decoded_t dec_o
);

    logic [31:0]              w;
    logic [exu_pkg::xlen-1:0] imm_i;
    logic [exu_pkg::xlen-1:0] imm_b;
    logic [exu_pkg::xlen-1:0] imm_u;
    logic [exu_pkg::xlen-1:0] imm_j;
    logic [3:0]               base_op; // funct3 mapping shared by R and I forms
    logic                     wen_raw;

    assign w     = instr_i;
    assign imm_i = {{20{w[31]}}, instr_i.i_fmt.imm12};
    assign imm_b = {{19{w[31]}}, w[31], w[7], w[30:25], w[11:8], 1'b0};
    assign imm_u = {w[31:12], 12'b0};
    assign imm_j = {{11{w[31]}}, w[31], w[19:12], w[20], w[30:21], 1'b0};

    always_comb begin
        case (instr_i.r_fmt.funct3)
            3'b000:  base_op = exu_pkg::alu_add;
            3'b001:  base_op = exu_pkg::alu_sll;
            3'b010:  base_op = exu_pkg::alu_slt;
            3'b011:  base_op = exu_pkg::alu_sltu;
            3'b100:  base_op = exu_pkg::alu_xor;
            3'b101:  base_op = exu_pkg::alu_srl;
            3'b110:  base_op = exu_pkg::alu_or;
            default: base_op = exu_pkg::alu_and;
        endcase
    end

    always_comb begin
        dec_o          = '0;
        dec_o.funct3   = instr_i.r_fmt.funct3;
        dec_o.rd       = instr_i.r_fmt.rd;
        dec_o.rs1      = instr_i.r_fmt.rs1;
        dec_o.rs2      = instr_i.r_fmt.rs2;
        dec_o.cls      = exu_pkg::cls_none;
        dec_o.alu_op   = exu_pkg::alu_add;
        dec_o.imm      = imm_i;
        wen_raw        = 1'b0;
        case (instr_i.r_fmt.opcode)
            exu_pkg::op_rtype: begin
                dec_o.cls = exu_pkg::cls_alu;
                wen_raw   = 1'b1;
                if (instr_i.r_fmt.funct7 == 7'b0) begin
                    dec_o.alu_op = base_op;
                end else if (instr_i.r_fmt.funct7 == exu_pkg::f7_alt &&
                             instr_i.r_fmt.funct3 == 3'b000) begin
                    dec_o.alu_op = exu_pkg::alu_sub;
                end else if (instr_i.r_fmt.funct7 == exu_pkg::f7_alt &&
                             instr_i.r_fmt.funct3 == 3'b101) begin
                    dec_o.alu_op = exu_pkg::alu_sra;
                end else begin
                    dec_o.cls = exu_pkg::cls_none;
                    wen_raw   = 1'b0;
                end
            end
            exu_pkg::op_itype: begin
                dec_o.cls      = exu_pkg::cls_alu;
                dec_o.b_is_imm = 1'b1;
                dec_o.alu_op   = base_op;
                wen_raw        = 1'b1;
                // shift immediates carry an upper field that must be legal
                if (instr_i.i_fmt.funct3 == 3'b101 &&
                    instr_i.i_fmt.imm12[11:5] == exu_pkg::f7_alt) begin
                    dec_o.alu_op = exu_pkg::alu_sra;
                end else if ((instr_i.i_fmt.funct3 == 3'b001 ||
                              instr_i.i_fmt.funct3 == 3'b101) &&
                             instr_i.i_fmt.imm12[11:5] != 7'b0) begin
                    dec_o.cls = exu_pkg::cls_none;
                    wen_raw   = 1'b0;
                end
            end
            exu_pkg::op_lui: begin
                dec_o.cls      = exu_pkg::cls_alu;
                dec_o.alu_op   = exu_pkg::alu_pass_b;
                dec_o.b_is_imm = 1'b1;
                dec_o.imm      = imm_u;
                wen_raw        = 1'b1;
            end
            exu_pkg::op_auipc: begin
                dec_o.cls      = exu_pkg::cls_alu;
                dec_o.a_is_pc  = 1'b1;
                dec_o.b_is_imm = 1'b1;
                dec_o.imm      = imm_u;
                wen_raw        = 1'b1;
            end
            exu_pkg::op_branch: begin
                dec_o.cls = exu_pkg::cls_branch;
                dec_o.imm = imm_b;
            end
            exu_pkg::op_jal: begin
                dec_o.cls = exu_pkg::cls_jal;
                dec_o.imm = imm_j;
                wen_raw   = 1'b1;
            end
            exu_pkg::op_jalr: begin
                if (instr_i.i_fmt.funct3 == 3'b000) begin
                    dec_o.cls = exu_pkg::cls_jalr;
                    wen_raw   = 1'b1;
                end
            end
            default: ; // unknown opcode, stays cls_none
        endcase
        dec_o.rd_wen = wen_raw && (instr_i.r_fmt.rd != '0);
    end

endmodule

`default_nettype wire

/* hdl/exu_regfile.sv */
`default_nettype none

module exu_regfile (
    input  wire logic                             clk,
    input  wire logic                             rst,
    input  wire logic [exu_pkg::reg_addr_w-1:0]   raddr1_i,
    input  wire logic [exu_pkg::reg_addr_w-1:0]   raddr2_i,
    output logic      [exu_pkg::xlen-1:0]         rdata1_o,
    output logic      [exu_pkg::xlen-1:0]         rdata2_o,
    input  wire logic                             wen_i,
    input  wire logic [exu_pkg::reg_addr_w-1:0]   waddr_i,
    input  wire logic [exu_pkg::xlen-1:0]         wdata_i
);

    logic [exu_pkg::xlen-1:0] regs [exu_pkg::num_regs];

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            for (int i = 0; i < exu_pkg::num_regs; i++) begin
                regs[i] <= '0;
            end
        end else if (wen_i && waddr_i != '0) begin // x0 never written
            regs[waddr_i] <= wdata_i;
        end
    end

    // combinational read ports
    assign rdata1_o = regs[raddr1_i];
    assign rdata2_o = regs[raddr2_i];

endmodule

`default_nettype wire

/* hdl/exu_alu.sv */
`default_nettype none

module exu_alu (
    input  exu_pkg::decoded_t                dec_i,
    input  wire logic [exu_pkg::xlen-1:0]    pc_i,
    input  wire logic [exu_pkg::xlen-1:0]    rs1_data_i,
    input  wire logic [exu_pkg::xlen-1:0]    rs2_data_i,
    output logic      [exu_pkg::xlen-1:0]    result_o
);

    logic [exu_pkg::xlen-1:0] op_a;
    logic [exu_pkg::xlen-1:0] op_b;
    logic [4:0]               shamt;
    logic                     lt_s;
    logic                     lt_u;

    // operand muxes
    assign op_a  = dec_i.a_is_pc ? pc_i : rs1_data_i;
    assign op_b  = dec_i.b_is_imm ? dec_i.imm : rs2_data_i;
    assign shamt = op_b[4:0];

    assign lt_s = $signed(op_a) < $signed(op_b);
    assign lt_u = op_a < op_b;

    always_comb begin
        case (dec_i.alu_op)
            exu_pkg::alu_add:    result_o = op_a + op_b;
            exu_pkg::alu_sub:    result_o = op_a - op_b;
            exu_pkg::alu_sll:    result_o = op_a << shamt;
            exu_pkg::alu_slt:    result_o = {{(exu_pkg::xlen-1){1'b0}}, lt_s};
            exu_pkg::alu_sltu:   result_o = {{(exu_pkg::xlen-1){1'b0}}, lt_u};
            exu_pkg::alu_xor:    result_o = op_a ^ op_b;
            exu_pkg::alu_srl:    result_o = op_a >> shamt;
            exu_pkg::alu_sra:    result_o = $unsigned($signed(op_a) >>> shamt);
            exu_pkg::alu_or:     result_o = op_a | op_b;
            exu_pkg::alu_and:    result_o = op_a & op_b;
            exu_pkg::alu_pass_b: result_o = op_b; // lui
            default:             result_o = op_a + op_b;
        endcase
    end

endmodule

`default_nettype wire

/* hdl/exu_branch.sv */
`default_nettype none

module exu_branch (
    input  exu_pkg::decoded_t                dec_i,
    input  wire logic [exu_pkg::xlen-1:0]    pc_i,
    input  wire logic [exu_pkg::xlen-1:0]    rs1_data_i,
    input  wire logic [exu_pkg::xlen-1:0]    rs2_data_i,
    output logic      [exu_pkg::xlen-1:0]    next_pc_o,
    output logic                             taken_o,
    output logic      [exu_pkg::xlen-1:0]    link_o
);

    logic                     cond;
    logic [exu_pkg::xlen-1:0] pc_rel;   // branch and jal target
    logic [exu_pkg::xlen-1:0] jalr_sum;

    assign pc_rel   = pc_i + dec_i.imm;
    assign jalr_sum = rs1_data_i + dec_i.imm;
    assign link_o   = pc_i + 32'd4;

    always_comb begin
        case (dec_i.funct3)
            exu_pkg::f3_beq:  cond = rs1_data_i == rs2_data_i;
            exu_pkg::f3_bne:  cond = rs1_data_i != rs2_data_i;
            exu_pkg::f3_blt:  cond = $signed(rs1_data_i) < $signed(rs2_data_i);
            exu_pkg::f3_bge:  cond = $signed(rs1_data_i) >= $signed(rs2_data_i);
            exu_pkg::f3_bltu: cond = rs1_data_i < rs2_data_i;
            exu_pkg::f3_bgeu: cond = rs1_data_i >= rs2_data_i;
            default:          cond = 1'b0; // 010/011 never taken
        endcase
    end

    always_comb begin
        next_pc_o = link_o;
        taken_o   = 1'b0;
        case (dec_i.cls)
            exu_pkg::cls_branch: begin
                taken_o   = cond;
                next_pc_o = cond ? pc_rel : link_o;
            end
            exu_pkg::cls_jal: begin
                taken_o   = 1'b1;
                next_pc_o = pc_rel;
            end
            exu_pkg::cls_jalr: begin
                taken_o   = 1'b1;
                next_pc_o = {jalr_sum[exu_pkg::xlen-1:1], 1'b0};
            end
            default: ;
        endcase
    end

endmodule

`default_nettype wire

/* hdl/exu_ctrl.sv */
`default_nettype none

module exu_ctrl (
    input  wire logic                             clk,
    input  wire logic                             rst,
    input  wire logic                             op_en_i,
    input  exu_pkg::instr_u                       op_i,
    input  wire logic [exu_pkg::xlen-1:0]         pc_i,
    output exu_pkg::instr_u                       instr_o,
    output logic      [exu_pkg::xlen-1:0]         pc_o,
    input  exu_pkg::decoded_t                     dec_i,
    input  wire logic [exu_pkg::xlen-1:0]         alu_result_i,
    input  wire logic [exu_pkg::xlen-1:0]         link_i,
    input  wire logic [exu_pkg::xlen-1:0]         next_pc_i,
    input  wire logic                             taken_i,
    output logic      [exu_pkg::reg_addr_w-1:0]   raddr1_o,
    output logic      [exu_pkg::reg_addr_w-1:0]   raddr2_o,
    output logic                                  rf_wen_o,
    output logic      [exu_pkg::reg_addr_w-1:0]   rf_waddr_o,
    output logic      [exu_pkg::xlen-1:0]         rf_wdata_o,
    output logic                                  ex_end_o,
    output logic      [exu_pkg::xlen-1:0]         next_pc_o,
    output logic                                  branch_taken_o,
    output exu_pkg::commit_t                      commit_o
);

    logic [1:0]               state;
    exu_pkg::instr_u          instr_q;
    logic [exu_pkg::xlen-1:0] pc_q;
    logic [exu_pkg::xlen-1:0] wdata_q;
    logic [exu_pkg::xlen-1:0] npc_q;
    logic                     taken_q;
    exu_pkg::commit_t         commit_q;
    logic                     is_jump;

    assign is_jump = dec_i.cls == exu_pkg::cls_jal || dec_i.cls == exu_pkg::cls_jalr;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state          <= exu_pkg::st_idle;
            ex_end_o       <= 1'b0;
            next_pc_o      <= '0;
            branch_taken_o <= 1'b0;
            commit_q       <= '0;
        end else begin
            commit_q.valid <= 1'b0; // single cycle pulse
            case (state)
                exu_pkg::st_idle: begin
                    if (op_en_i) state <= exu_pkg::st_execute;
                end
                exu_pkg::st_execute: state <= exu_pkg::st_writeback;
                exu_pkg::st_writeback: begin
                    state          <= exu_pkg::st_idle;
                    ex_end_o       <= ~ex_end_o;
                    next_pc_o      <= npc_q;
                    branch_taken_o <= taken_q;
                    commit_q.valid <= dec_i.rd_wen;
                    commit_q.rd    <= dec_i.rd;
                    commit_q.data  <= wdata_q;
                end
                default: state <= exu_pkg::st_idle;
            endcase
        end
    end

    // instruction latch and execute results
    always_ff @(posedge clk) begin
        if (state == exu_pkg::st_idle && op_en_i) begin
            instr_q <= op_i;
            pc_q    <= pc_i;
        end
        if (state == exu_pkg::st_execute) begin
            wdata_q <= is_jump ? link_i : alu_result_i;
            npc_q   <= next_pc_i;
            taken_q <= taken_i;
        end
    end

    assign instr_o    = instr_q;
    assign pc_o       = pc_q;
    assign raddr1_o   = dec_i.rs1;
    assign raddr2_o   = dec_i.rs2;
    assign rf_wen_o   = (state == exu_pkg::st_writeback) && dec_i.rd_wen;
    assign rf_waddr_o = dec_i.rd;
    assign rf_wdata_o = wdata_q;
    assign commit_o   = commit_q;

endmodule

`default_nettype wire

/* hdl/exu_top.sv */
`default_nettype none

module exu_top (
    input  wire logic                          clk,
    input  wire logic                          rst,
    input  exu_pkg::instr_u                    op_i,
    input  wire logic                          op_en_i,
    input  wire logic [exu_pkg::xlen-1:0]      pc_i,
    output logic                               ex_end_o,
    output logic      [exu_pkg::xlen-1:0]      next_pc_o,
    output logic                               branch_taken_o,
    output exu_pkg::commit_t                   commit_o
);

    exu_pkg::instr_u                  instr;
    exu_pkg::decoded_t                dec;
    logic [exu_pkg::xlen-1:0]         pc;
    logic [exu_pkg::reg_addr_w-1:0]   raddr1;
    logic [exu_pkg::reg_addr_w-1:0]   raddr2;
    logic [exu_pkg::xlen-1:0]         rdata1;
    logic [exu_pkg::xlen-1:0]         rdata2;
    logic                             rf_wen;
    logic [exu_pkg::reg_addr_w-1:0]   rf_waddr;
    logic [exu_pkg::xlen-1:0]         rf_wdata;
    logic [exu_pkg::xlen-1:0]         alu_result;
    logic [exu_pkg::xlen-1:0]         link;
    logic [exu_pkg::xlen-1:0]         br_next_pc;
    logic                             br_taken;

    exu_ctrl u_ctrl (
        .clk(clk), .rst(rst),
        .op_en_i(op_en_i), .op_i(op_i), .pc_i(pc_i),
        .instr_o(instr), .pc_o(pc), .dec_i(dec),
        .alu_result_i(alu_result), .link_i(link),
        .next_pc_i(br_next_pc), .taken_i(br_taken),
        .raddr1_o(raddr1), .raddr2_o(raddr2),
        .rf_wen_o(rf_wen), .rf_waddr_o(rf_waddr), .rf_wdata_o(rf_wdata),
        .ex_end_o(ex_end_o), .next_pc_o(next_pc_o),
        .branch_taken_o(branch_taken_o), .commit_o(commit_o)
    );

    exu_decoder u_decoder (.instr_i(instr), .dec_o(dec));

    exu_regfile u_regfile (
        .clk(clk), .rst(rst),
        .raddr1_i(raddr1), .raddr2_i(raddr2),
        .rdata1_o(rdata1), .rdata2_o(rdata2),
        .wen_i(rf_wen), .waddr_i(rf_waddr), .wdata_i(rf_wdata)
    );

    exu_alu u_alu (
        .dec_i(dec), .pc_i(pc),
        .rs1_data_i(rdata1), .rs2_data_i(rdata2),
        .result_o(alu_result)
    );

    exu_branch u_branch (
        .dec_i(dec), .pc_i(pc),
        .rs1_data_i(rdata1), .rs2_data_i(rdata2),
        .next_pc_o(br_next_pc), .taken_o(br_taken), .link_o(link)
    );

endmodule

`default_nettype wire

/* verif/exu_clk_gen.sv */
`default_nettype none

module exu_clk_gen (
    output logic clk_o
);
    timeunit 1ns;
    timeprecision 100ps;

    // free running, 10 ns period
    initial begin
        clk_o = 1'b0;
        forever #5 clk_o = ~clk_o;
    end

endmodule

`default_nettype wire

/* verif/exu_tb.sv */
`default_nettype none

module exu_tb;
    timeunit 1ns;
    timeprecision 100ps;

    logic                     clk;
    logic                     rst;
    exu_pkg::instr_u          op_i;
    logic                     op_en_i;
    logic [exu_pkg::xlen-1:0] pc_i;
    logic                     ex_end_o;
    logic [exu_pkg::xlen-1:0] next_pc_o;
    logic                     branch_taken_o;
    exu_pkg::commit_t         commit_o;

    logic [exu_pkg::xlen-1:0] model_regs [exu_pkg::num_regs]; // reference register file
    int                       n_instr;

    exu_clk_gen clk_gen_inst (.clk_o(clk));

    exu_top exu_top_inst (
        .clk(clk), .rst(rst),
        .op_i(op_i), .op_en_i(op_en_i), .pc_i(pc_i),
        .ex_end_o(ex_end_o), .next_pc_o(next_pc_o),
        .branch_taken_o(branch_taken_o), .commit_o(commit_o)
    );

    task automatic stop_run();
        $display("FAIL: see errors above");
        $fatal(1, "stopping at first error");
    endtask

    task automatic check_word(input string name, input logic [exu_pkg::xlen-1:0] got,
                              input logic [exu_pkg::xlen-1:0] exp);
        if (got !== exp) begin
            $display("CHECK FAILED at %0t: %s = 0x%08h, expected 0x%08h", $time, name, got, exp);
            stop_run();
        end
    endtask

    task automatic check_bit(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            $display("CHECK FAILED at %0t: %s = %b, expected %b", $time, name, got, exp);
            stop_run();
        end
    endtask

    task automatic check_reg(input string name, input logic [exu_pkg::reg_addr_w-1:0] got,
                             input logic [exu_pkg::reg_addr_w-1:0] exp);
        if (got !== exp) begin
            $display("CHECK FAILED at %0t: %s = x%0d, expected x%0d", $time, name, got, exp);
            stop_run();
        end
    endtask

    function automatic logic [exu_pkg::xlen-1:0] sext12(input logic [11:0] imm);
        return {{20{imm[11]}}, imm};
    endfunction

    function automatic logic [exu_pkg::xlen-1:0] sext13(input logic [12:0] imm);
        return {{19{imm[12]}}, imm};
    endfunction

    function automatic logic [exu_pkg::xlen-1:0] sext21(input logic [20:0] imm);
        return {{11{imm[20]}}, imm};
    endfunction

    // RV32I integer result by funct3, alt selects sub / arithmetic shift
    function automatic logic [exu_pkg::xlen-1:0] alu_ref(input logic [2:0] f3, input logic alt,
                                                         input logic [exu_pkg::xlen-1:0] a,
                                                         input logic [exu_pkg::xlen-1:0] b);
        logic [exu_pkg::xlen-1:0] r;
        case (f3)
            3'd0:    r = alt ? a - b : a + b;
            3'd1:    r = a << b[4:0];
            3'd2:    r = {{(exu_pkg::xlen-1){1'b0}}, $signed(a) < $signed(b)};
            3'd3:    r = {{(exu_pkg::xlen-1){1'b0}}, a < b};
            3'd4:    r = a ^ b;
            3'd5:    r = alt ? $unsigned($signed(a) >>> b[4:0]) : a >> b[4:0];
            3'd6:    r = a | b;
            default: r = a & b;
        endcase
        return r;
    endfunction

    function automatic logic branch_ref(input logic [2:0] f3, input logic [exu_pkg::xlen-1:0] a,
                                        input logic [exu_pkg::xlen-1:0] b);
        case (f3)
            3'd0:    return a == b;
            3'd1:    return a != b;
            3'd4:    return $signed(a) < $signed(b);
            3'd5:    return $signed(a) >= $signed(b);
            3'd6:    return a < b;
            3'd7:    return a >= b;
            default: return 1'b0;
        endcase
    endfunction

    // instruction encoders
    function automatic logic [31:0] enc_r(input logic [6:0] f7, input logic [4:0] rs2,
                                          input logic [4:0] rs1, input logic [2:0] f3,
                                          input logic [4:0] rd, input logic [6:0] opc);
        return {f7, rs2, rs1, f3, rd, opc};
    endfunction

    function automatic logic [31:0] enc_i(input logic [11:0] imm, input logic [4:0] rs1,
                                          input logic [2:0] f3, input logic [4:0] rd,
                                          input logic [6:0] opc);
        return {imm, rs1, f3, rd, opc};
    endfunction

    function automatic logic [31:0] enc_b(input logic [12:0] imm, input logic [4:0] rs2,
                                          input logic [4:0] rs1, input logic [2:0] f3);
        return {imm[12], imm[10:5], rs2, rs1, f3, imm[4:1], imm[11], exu_pkg::op_branch};
    endfunction

    function automatic logic [31:0] enc_j(input logic [20:0] imm, input logic [4:0] rd);
        return {imm[20], imm[10:1], imm[11], imm[19:12], rd, exu_pkg::op_jal};
    endfunction

    function automatic logic [4:0] rnd_reg();
        logic [31:0] t;
        t = $urandom;
        return t[4:0];
    endfunction

    function automatic logic [exu_pkg::xlen-1:0] rnd_pc();
        logic [31:0] t;
        t = $urandom;
        return {t[31:2], 2'b00}; // word aligned
    endfunction

    // one strobe, wait for the ex_end_o toggle, compare against the model
    task automatic run_instr(input logic [31:0] word, input logic [exu_pkg::xlen-1:0] pc,
                             input logic exp_valid, input logic [4:0] exp_rd,
                             input logic [exu_pkg::xlen-1:0] exp_data,
                             input logic [exu_pkg::xlen-1:0] exp_npc, input logic exp_taken);
        logic end_before;
        logic done;
        int   cycles;
        end_before = ex_end_o;
        op_i       = word;
        pc_i       = pc;
        op_en_i    = 1'b1;
        @(posedge clk);
        #1;
        op_en_i = 1'b0;
        done    = 1'b0;
        cycles  = 0;
        while (!done) begin
            if (ex_end_o !== end_before) begin
                done = 1'b1;
            end else begin
                if (commit_o.valid !== 1'b0) begin
                    $display("commit pulse seen at %0t before the instruction finished", $time);
                    stop_run();
                end
                if (cycles == 20) begin
                    $display("timeout at %0t: ex_end_o did not toggle within 20 cycles", $time);
                    stop_run();
                end
                cycles++;
                @(posedge clk);
                #1;
            end
        end
        check_word("next_pc_o", next_pc_o, exp_npc);
        check_bit("branch_taken_o", branch_taken_o, exp_taken);
        check_bit("commit_o.valid", commit_o.valid, exp_valid);
        if (exp_valid) begin
            check_reg("commit_o.rd", commit_o.rd, exp_rd);
            check_word("commit_o.data", commit_o.data, exp_data);
            model_regs[exp_rd] = exp_data;
        end
        n_instr++;
    endtask

    // lui + addi into every register
    task automatic seed_regs();
        logic [31:0]              value;
        logic [19:0]              upper;
        logic [4:0]               rd;
        logic [exu_pkg::xlen-1:0] pc;
        for (int r = 1; r < exu_pkg::num_regs; r++) begin
            rd    = r[4:0];
            value = $urandom;
            upper = value[31:12] + {19'b0, value[11]}; // addi sign extends the low part
            pc    = rnd_pc();
            run_instr({upper, rd, exu_pkg::op_lui}, pc, 1'b1, rd, {upper, 12'b0},
                      pc + 32'd4, 1'b0);
            pc = rnd_pc();
            run_instr(enc_i(value[11:0], rd, 3'b000, rd, exu_pkg::op_itype), pc, 1'b1, rd,
                      alu_ref(3'b000, 1'b0, model_regs[rd], sext12(value[11:0])),
                      pc + 32'd4, 1'b0);
        end
    endtask

    task automatic test_rtype();
        logic [31:0]              t;
        logic [2:0]               f3;
        logic                     alt;
        logic [4:0]               rs1;
        logic [4:0]               rs2;
        logic [4:0]               rd;
        logic [exu_pkg::xlen-1:0] pc;
        repeat (80) begin
            t   = $urandom;
            f3  = t[2:0];
            alt = t[3] && (f3 == 3'b000 || f3 == 3'b101);
            rs1 = rnd_reg();
            rs2 = rnd_reg();
            rd  = rnd_reg();
            pc  = rnd_pc();
            run_instr(enc_r(alt ? exu_pkg::f7_alt : 7'b0, rs2, rs1, f3, rd, exu_pkg::op_rtype),
                      pc, rd != 5'd0, rd, alu_ref(f3, alt, model_regs[rs1], model_regs[rs2]),
                      pc + 32'd4, 1'b0);
        end
    endtask

    task automatic test_itype();
        logic [31:0]              t;
        logic [2:0]               f3;
        logic [11:0]              imm;
        logic                     bad;
        logic [4:0]               rs1;
        logic [4:0]               rd;
        logic [exu_pkg::xlen-1:0] pc;
        repeat (80) begin
            t   = $urandom;
            f3  = t[2:0];
            imm = t[15:4];
            bad = 1'b0;
            rs1 = rnd_reg();
            rd  = rnd_reg();
            pc  = rnd_pc();
            if (f3 == 3'b001) imm[11:5] = 7'b0;
            if (f3 == 3'b101) imm[11:5] = t[16] ? exu_pkg::f7_alt : 7'b0;
            if ((f3 == 3'b001 || f3 == 3'b101) && t[19:17] == 3'b000) begin
                imm[11:5] = t[26:20] | 7'b0000001; // illegal shift upper field
                bad       = 1'b1;
            end
            run_instr(enc_i(imm, rs1, f3, rd, exu_pkg::op_itype), pc, !bad && rd != 5'd0, rd,
                      alu_ref(f3, f3 == 3'b101 && imm[10], model_regs[rs1], sext12(imm)),
                      pc + 32'd4, 1'b0);
        end
        // sltiu against negative immediates
        foreach (model_regs[r]) begin
            pc = rnd_pc();
            imm = r[0] ? 12'hfff : 12'h800;
            run_instr(enc_i(imm, r[4:0], 3'b011, 5'd3, exu_pkg::op_itype), pc, 1'b1, 5'd3,
                      {31'b0, model_regs[r] < sext12(imm)}, pc + 32'd4, 1'b0);
        end
    endtask

    task automatic test_upper();
        logic [31:0]              t;
        logic [4:0]               rd;
        logic [exu_pkg::xlen-1:0] pc;
        repeat (12) begin
            t  = $urandom;
            rd = rnd_reg();
            pc = rnd_pc();
            run_instr({t[31:12], rd, exu_pkg::op_lui}, pc, rd != 5'd0, rd, {t[31:12], 12'b0},
                      pc + 32'd4, 1'b0);
            run_instr({t[31:12], rd, exu_pkg::op_auipc}, pc, rd != 5'd0, rd,
                      pc + {t[31:12], 12'b0}, pc + 32'd4, 1'b0);
        end
    endtask

    task automatic test_branch();
        logic [31:0]              t;
        logic [2:0]               f3;
        logic [12:0]              imm;
        logic                     taken;
        logic [4:0]               rs1;
        logic [4:0]               rs2;
        logic [exu_pkg::xlen-1:0] pc;
        repeat (80) begin
            t   = $urandom;
            f3  = t[2:0];
            if (f3[2:1] == 2'b01) f3[2] = 1'b1; // no branch for 010 / 011
            rs1 = rnd_reg();
            rs2 = (t[4:3] == 2'b00) ? rs1 : rnd_reg(); // equal operands now and then
            imm = {t[23:12], 1'b0};
            pc  = rnd_pc();
            taken = branch_ref(f3, model_regs[rs1], model_regs[rs2]);
            run_instr(enc_b(imm, rs2, rs1, f3), pc, 1'b0, 5'd0, '0,
                      taken ? pc + sext13(imm) : pc + 32'd4, taken);
        end
    endtask

    task automatic test_jumps();
        logic [31:0]              t;
        logic [4:0]               rs1;
        logic [4:0]               rd;
        logic [exu_pkg::xlen-1:0] pc;
        logic [exu_pkg::xlen-1:0] target;
        repeat (20) begin
            t  = $urandom;
            rd = rnd_reg();
            pc = rnd_pc();
            run_instr(enc_j({t[20:1], 1'b0}, rd), pc, rd != 5'd0, rd, pc + 32'd4,
                      pc + sext21({t[20:1], 1'b0}), 1'b1);
            rs1    = rnd_reg();
            rd     = rnd_reg();
            pc     = rnd_pc();
            target = model_regs[rs1] + sext12(t[31:20]);
            target[0] = 1'b0;
            run_instr(enc_i(t[31:20], rs1, 3'b000, rd, exu_pkg::op_jalr), pc, rd != 5'd0, rd,
                      pc + 32'd4, target, 1'b1);
        end
    endtask

    task automatic test_no_effect();
        logic [31:0]              t;
        logic [6:0]               bad_ops [4];
        logic [exu_pkg::xlen-1:0] pc;
        bad_ops = '{7'b0000011, 7'b0100011, 7'b1110011, 7'b0001111}; // load store system fence
        t  = $urandom;
        pc = rnd_pc();
        run_instr(enc_i(t[11:0], rnd_reg(), 3'b000, 5'd0, exu_pkg::op_itype), pc, 1'b0, 5'd0,
                  '0, pc + 32'd4, 1'b0);
        run_instr({t[31:12], 5'd0, exu_pkg::op_lui}, pc, 1'b0, 5'd0, '0, pc + 32'd4, 1'b0);
        foreach (bad_ops[i]) begin
            pc = rnd_pc();
            run_instr({t[31:12], 5'd9, bad_ops[i]}, pc, 1'b0, 5'd0, '0, pc + 32'd4, 1'b0);
        end
        // x0 as a source reads zero
        pc = rnd_pc();
        run_instr(enc_r(7'b0, 5'd7, 5'd0, 3'b000, 5'd5, exu_pkg::op_rtype), pc, 1'b1, 5'd5,
                  model_regs[7], pc + 32'd4, 1'b0);
        run_instr(enc_r(exu_pkg::f7_alt, 5'd0, 5'd7, 3'b000, 5'd6, exu_pkg::op_rtype), pc,
                  1'b1, 5'd6, model_regs[7], pc + 32'd4, 1'b0);
    endtask

    initial begin
        rst     = 1'b1;
        op_en_i = 1'b0;
        op_i    = '0;
        pc_i    = '0;
        n_instr = 0;
        foreach (model_regs[i]) model_regs[i] = '0;
        void'($urandom(32'h991cbac7));
        repeat (4) @(posedge clk);
        #1;
        rst = 1'b0;
        check_bit("ex_end_o", ex_end_o, 1'b0);
        check_word("next_pc_o", next_pc_o, '0);
        check_bit("branch_taken_o", branch_taken_o, 1'b0);
        check_bit("commit_o.valid", commit_o.valid, 1'b0);
        seed_regs();
        test_rtype();
        test_itype();
        test_upper();
        test_branch();
        test_jumps();
        test_no_effect();
        $display("%0d instructions checked", n_instr);
        $display("PASS: all tests");
        $finish;
    end

endmodule

`default_nettype wire

/* exu_top.f */
hdl/exu_pkg.sv
hdl/exu_decoder.sv
hdl/exu_regfile.sv
hdl/exu_alu.sv
hdl/exu_branch.sv
hdl/exu_ctrl.sv
hdl/exu_top.sv
verif/exu_clk_gen.sv
verif/exu_tb.sv

/* run_sim.sh */
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --top-module exu_tb -Mdir obj_dir -o exu_sim -f exu_top.f

# $fatal exits non-zero, the log decides the verdict
./obj_dir/exu_sim > sim.log 2>&1 || true
cat sim.log

if grep -q "FAIL: see errors above" sim.log; then
    exit 1
fi
grep -q "PASS: all tests" sim.log
